// File: Makefile
# Verilator build of the RoCE v2 transmit testbench.

VERILATOR ?= verilator
TOP       ?= tb_roce_stack
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT ?= TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(SIM_BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
+incdir+verilog
+incdir+testbench
verilog/roce_pkg.sv
verilog/roce_qp_config.sv
verilog/roce_payload_gen.sv
verilog/roce_tx_framer.sv
verilog/roce_stack_top.sv
testbench/tb_roce_stack.sv

// File: testbench/roce_vectors.txt
# dma_length pmtu rem_psn rem_qpn r_key rem_addr, all in hex.
# One RDMA WRITE transfer per line, pmtu a multiple of 8 bytes.
00000040 0040 000000 000011 0badcafe 0000000010000000
00000064 0040 000100 000012 11223344 0000000020000040
000001f4 0080 fffffe 000abc 55aa55aa 00007f0012345000
00000003 0100 123456 ffffff deadbeef ffffffff00000000
00000800 0100 00ffff 000400 a5a5a5a5 0000001000000000
00000401 0200 7ffffe 000401 01020304 0000000000001000
00000238 0008 fffff0 000020 cafef00d 0000000000000800
000007d0 0400 abcdef 000777 0f0f0f0f 0000000000400000

// File: testbench/tb_roce_checks.svh
`ifndef TB_ROCE_CHECKS_SVH
`define TB_ROCE_CHECKS_SVH

  // 32-bit xorshift step.
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_beat(input string name, input roce_beat_t got, input roce_beat_t exp);
    if (got !== exp) begin
      abort_run({$sformatf("ERR %s exp data=%h keep=%h first=%h last=%h",
                           name, exp.data, exp.keep, exp.first, exp.last),
                 $sformatf(" got data=%h keep=%h first=%h last=%h",
                           got.data, got.keep, got.first, got.last)});
    end
  endtask

  task automatic check_hdr(input string name, input roce_hdr_t got, input roce_hdr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s exp op=%h psn=%h hdr=%h got op=%h psn=%h hdr=%h",
                          name, exp.op_code, exp.psn, exp, got.op_code, got.psn, got));
    end
  endtask

  task automatic verify_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s exp %h got %h", name, exp, got));
    end
  endtask

`endif

// File: testbench/tb_roce_stack.sv
`timescale 1ns/1ps
`include "roce_consts.svh"

module tb_roce_stack;
  import roce_pkg::*;

  localparam string VEC_FILE = "testbench/roce_vectors.txt";

  logic        clk;
  logic        rst;
  qp_cfg_t     cfg;
  logic        start;
  logic        credit_return;
  logic        tx_valid;
  roce_beat_t  tx_beat;
  roce_hdr_t   tx_hdr;
  logic        busy;

  roce_beat_t  exp_beats[$];
  roce_hdr_t   exp_hdrs[$];    // One entry per beat, the header of its packet.
  int          beats_seen;
  int          credits_back;
  logic [7:0]  hold_cycles;
  logic [31:0] rnd_state;

  `include "tb_roce_checks.svh"

  roce_stack_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .cfg           (cfg),
    .start         (start),
    .credit_return (credit_return),
    .tx_valid      (tx_valid),
    .tx_beat       (tx_beat),
    .tx_hdr        (tx_hdr),
    .busy          (busy)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Builds the beats and headers that one transfer must produce.
  task automatic load_expected(input qp_cfg_t c);
    int unsigned len;
    int unsigned mtu;
    int unsigned n_beats;
    int unsigned n_pkts;
    int unsigned k;
    int unsigned off;
    int unsigned pkt_off;
    int unsigned pkt_idx;
    roce_beat_t  b;
    roce_hdr_t   h;
    len     = c.dma_length;
    mtu     = {19'b0, c.pmtu};
    n_beats = (len + 7) / 8;
    n_pkts  = (len + mtu - 1) / mtu;
    for (k = 0; k < n_beats; k++) begin
      off     = 8 * k;
      pkt_off = off % mtu;
      pkt_idx = off / mtu;
      b.data  = {~off, off};
      b.keep  = 8'hff;
      if (k == n_beats - 1 && len % 8 != 0) begin
        b.keep = 8'hff >> (8 - len % 8);  // Only the tail bytes of the final word.
      end
      b.first = (pkt_off == 0);
      b.last  = (k == n_beats - 1) || ((off + 8) % mtu == 0);  // Next word opens a packet.
      h = '0;
      if (n_pkts == 1) begin
        h.op_code = `ROCE_OP_WRITE_ONLY;
      end else if (pkt_idx == 0) begin
        h.op_code = `ROCE_OP_WRITE_FIRST;
      end else if (pkt_idx == n_pkts - 1) begin
        h.op_code = `ROCE_OP_WRITE_LAST;
      end else begin
        h.op_code = `ROCE_OP_WRITE_MIDDLE;
      end
      h.psn          = c.rem_psn + pkt_idx[23:0];  // Wraps at 2^24.
      h.dest_qp      = c.rem_qpn;
      h.ack_req      = (pkt_idx == n_pkts - 1);
      h.reth_present = (pkt_idx == 0);
      if (pkt_idx == 0) begin
        h.v_addr  = c.rem_addr;
        h.r_key   = c.r_key;
        h.dma_len = c.dma_length;
      end
      exp_beats.push_back(b);
      exp_hdrs.push_back(h);
    end
  endtask

  task automatic run_transfer(input qp_cfg_t c, input bit poke_busy);
    int wait_cnt;
    load_expected(c);
    cfg   = c;
    start = 1'b1;
    @(negedge clk);
    start    = 1'b0;
    wait_cnt = 0;
    while (!busy) begin
      if (wait_cnt == `ROCE_TIMEOUT) abort_run("timeout waiting for busy to rise");
      wait_cnt++;
      @(negedge clk);
    end
    if (poke_busy) begin
      @(negedge clk);
      cfg   = ~c;  // A second start with other values must be ignored.
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      cfg   = c;
    end
    wait_cnt = 0;
    while (busy) begin
      if (wait_cnt == `ROCE_TIMEOUT) abort_run("timeout waiting for the transfer to end");
      wait_cnt++;
      @(negedge clk);
    end
    if (exp_beats.size() != 0) begin
      abort_run($sformatf("transfer ended with %0d beats never seen", exp_beats.size()));
    end
  endtask

  // Output monitor and credit return toward the DUT.
  always @(negedge clk) begin : sink_side
    logic [31:0] rnd;
    if (tx_valid) begin
      if (exp_beats.size() == 0) abort_run("a beat came out with no transfer pending");
      if (!busy) abort_run("a beat came out while busy was low");
      beats_seen++;
      if (beats_seen > `ROCE_TX_CREDITS + credits_back) begin
        abort_run("more beats came out than the credits allow");
      end
      check_beat("tx_beat", tx_beat, exp_beats.pop_front());
      check_hdr("tx_hdr", tx_hdr, exp_hdrs.pop_front());
    end
    credit_return = 1'b0;
    rnd       = xorshift32(rnd_state);
    rnd_state = rnd;
    if (hold_cycles != 8'd0) begin
      hold_cycles = hold_cycles - 8'd1;
    end else if (rnd[9:0] < 10'd4) begin
      hold_cycles = rnd[17:10];  // Withhold credits for a while.
    end else if (beats_seen > credits_back && rnd[1:0] != 2'b00) begin
      credit_return = 1'b1;
      credits_back++;
    end
  end

  initial begin
    int          fd;
    int          n;
    int          idx;
    string       line;
    qp_cfg_t     c;
    logic [31:0] len_v;
    logic [12:0] mtu_v;
    logic [23:0] psn_v;
    logic [23:0] qpn_v;
    logic [31:0] key_v;
    logic [63:0] addr_v;
    clk           = 1'b0;
    rst           = 1'b1;
    cfg           = '0;
    start         = 1'b0;
    credit_return = 1'b0;
    rnd_state     = 32'h42775ade;
    hold_cycles   = 8'd0;
    beats_seen    = 0;
    credits_back  = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    verify_flag("busy", busy, 1'b0);
    verify_flag("tx_valid", tx_valid, 1'b0);
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) abort_run("cannot open the vector file");
    idx = 0;
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h", len_v, mtu_v, psn_v, qpn_v, key_v, addr_v);
      if (n != 6) abort_run("malformed line in the vector file");
      c.dma_length = len_v;
      c.pmtu       = mtu_v;
      c.rem_psn    = psn_v;
      c.rem_qpn    = qpn_v;
      c.r_key      = key_v;
      c.rem_addr   = addr_v;
      run_transfer(c, idx % 2 == 1);
      idx++;
    end
    $fclose(fd);
    if (idx == 0) begin
      abort_run("the vector file holds no transfers");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: verilog/roce_consts.svh
`ifndef ROCE_CONSTS_SVH
`define ROCE_CONSTS_SVH

// Datapath and header field widths.
`define ROCE_DATA_W 64
`define ROCE_KEEP_W 8
`define ROCE_PSN_W  24
`define ROCE_LEN_W  32

// RDMA WRITE opcodes of the RC transport.
`define ROCE_OP_WRITE_FIRST  8'h06
`define ROCE_OP_WRITE_MIDDLE 8'h07
`define ROCE_OP_WRITE_LAST   8'h08
`define ROCE_OP_WRITE_ONLY   8'h0A

`define ROCE_TX_CREDITS 8     // Beats the sink buffers before it must return credits.

`define ROCE_TIMEOUT 5000     // Cycles.

`endif

// File: verilog/roce_payload_gen.sv
`timescale 1ns/1ps
`include "roce_consts.svh"

module roce_payload_gen (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   busy,
  input  logic [`ROCE_LEN_W-1:0] dma_length,
  output logic                   pl_valid,
  output roce_pkg::roce_beat_t   pl_beat,
  input  logic                   pl_ready
);
  import roce_pkg::*;

  localparam int TAIL_W = $clog2(`ROCE_KEEP_W);

  logic [`ROCE_LEN_W-1:0]  offset;
  logic                    busy_d;
  logic                    final_beat;
  logic [TAIL_W-1:0]       tail_bytes;
  logic [`ROCE_KEEP_W-1:0] tail_keep;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_d <= 1'b0;
      offset <= '0;
    end else begin
      busy_d <= busy;
      if (busy && !busy_d) begin
        offset <= '0;  // New transfer.
      end else if (pl_valid && pl_ready) begin
        offset <= offset + `ROCE_KEEP_W;
      end
    end
  end

  assign pl_valid   = busy_d && (offset < dma_length);
  assign final_beat = (dma_length - offset) <= `ROCE_KEEP_W;

  // Bytes in the final word, zero meaning a full word.
  assign tail_bytes = dma_length[TAIL_W-1:0];
  assign tail_keep  = (tail_bytes == '0) ? '1 : ~({`ROCE_KEEP_W{1'b1}} << tail_bytes);

  always_comb begin
    pl_beat.data  = {~offset, offset};
    pl_beat.keep  = final_beat ? tail_keep : '1;
    pl_beat.first = 1'b0;  // Packet boundaries are the framer's job.
    pl_beat.last  = 1'b0;
  end

endmodule

// File: verilog/roce_pkg.sv
`include "roce_consts.svh"

package roce_pkg;

  // Queue pair values for one DMA transfer.
  typedef struct packed {
    logic [`ROCE_LEN_W-1:0] dma_length;  // Total bytes to write.
    logic [12:0]            pmtu;        // Path MTU in bytes.
    logic [`ROCE_PSN_W-1:0] rem_psn;     // PSN of the first packet.
    logic [23:0]            rem_qpn;
    logic [31:0]            r_key;
    logic [63:0]            rem_addr;
  } qp_cfg_t;

  // One 64-bit word of the payload stream.
  typedef struct packed {
    logic [`ROCE_DATA_W-1:0] data;
    logic [`ROCE_KEEP_W-1:0] keep;
    logic                    first;      // First beat of a packet.
    logic                    last;       // Last beat of a packet.
  } roce_beat_t;

  // BTH and RETH fields of the packet on the output.
  typedef struct packed {
    logic [7:0]             op_code;
    logic [`ROCE_PSN_W-1:0] psn;
    logic [23:0]            dest_qp;
    logic                   ack_req;
    logic                   reth_present;
    logic [63:0]            v_addr;
    logic [31:0]            r_key;
    logic [31:0]            dma_len;
  } roce_hdr_t;

endpackage

// File: verilog/roce_qp_config.sv
`timescale 1ns/1ps
`include "roce_consts.svh"

module roce_qp_config (
  input  logic                   clk,
  input  logic                   rst,
  input  roce_pkg::qp_cfg_t      cfg,
  input  logic                   start,
  input  logic                   pkt_done,
  output roce_pkg::qp_cfg_t      qp,
  output logic [`ROCE_PSN_W-1:0] cur_psn,
  output logic                   pkt_index_first,
  output logic                   busy
);
  import roce_pkg::*;

  logic [`ROCE_LEN_W-1:0] bytes_left;
  logic [`ROCE_LEN_W-1:0] bytes_left_next;
  logic [`ROCE_LEN_W-1:0] pmtu_len;
  logic                   start_ok;

  assign start_ok = start && !busy;
  assign pmtu_len = {{(`ROCE_LEN_W - $bits(qp.pmtu)){1'b0}}, qp.pmtu};
  // Every packet but the final one carries a full pmtu.
  assign bytes_left_next = (bytes_left > pmtu_len) ? bytes_left - pmtu_len : '0;

  always_ff @(posedge clk) begin
    if (start_ok) begin
      qp <= cfg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy            <= 1'b0;
      bytes_left      <= '0;
      cur_psn         <= '0;
      pkt_index_first <= 1'b0;
    end else if (start_ok) begin
      busy            <= (cfg.dma_length != '0);  // An empty transfer sends nothing.
      bytes_left      <= cfg.dma_length;
      cur_psn         <= cfg.rem_psn;
      pkt_index_first <= 1'b1;
    end else if (pkt_done) begin
      bytes_left      <= bytes_left_next;
      cur_psn         <= cur_psn + 1'b1;  // Wraps at 24 bits.
      pkt_index_first <= 1'b0;
      if (bytes_left_next == '0) begin
        busy <= 1'b0;
      end
    end
  end

  ap_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $warning("roce_qp_config: start ignored while a transfer is running");

  // The framer must not finish packets the config block never started.
  ap_done_busy: assert property (@(posedge clk) disable iff (rst) pkt_done |-> busy);

endmodule

// File: verilog/roce_stack_top.sv
`timescale 1ns/1ps
`include "roce_consts.svh"

module roce_stack_top (
  input  logic                 clk,
  input  logic                 rst,
  input  roce_pkg::qp_cfg_t    cfg,
  input  logic                 start,
  input  logic                 credit_return,
  output logic                 tx_valid,
  output roce_pkg::roce_beat_t tx_beat,
  output roce_pkg::roce_hdr_t  tx_hdr,
  output logic                 busy
);
  import roce_pkg::*;

  qp_cfg_t                qp;
  logic [`ROCE_PSN_W-1:0] cur_psn;
  logic                   pkt_index_first;
  logic                   pkt_done;
  logic                   pl_valid;
  logic                   pl_ready;
  roce_beat_t             pl_beat;

  roce_qp_config u_qp_config (
    .clk             (clk),
    .rst             (rst),
    .cfg             (cfg),
    .start           (start),
    .pkt_done        (pkt_done),
    .qp              (qp),
    .cur_psn         (cur_psn),
    .pkt_index_first (pkt_index_first),
    .busy            (busy)
  );

  roce_payload_gen u_payload_gen (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .dma_length (qp.dma_length),
    .pl_valid   (pl_valid),
    .pl_beat    (pl_beat),
    .pl_ready   (pl_ready)
  );

  roce_tx_framer u_tx_framer (
    .clk             (clk),
    .rst             (rst),
    .qp              (qp),
    .cur_psn         (cur_psn),
    .pkt_index_first (pkt_index_first),
    .pl_valid        (pl_valid),
    .pl_beat         (pl_beat),
    .pl_ready        (pl_ready),
    .credit_return   (credit_return),
    .tx_valid        (tx_valid),
    .tx_beat         (tx_beat),
    .tx_hdr          (tx_hdr),
    .pkt_done        (pkt_done)
  );

endmodule

// File: verilog/roce_tx_framer.sv
`timescale 1ns/1ps
`include "roce_consts.svh"

module roce_tx_framer (
  input  logic                   clk,
  input  logic                   rst,
  input  roce_pkg::qp_cfg_t      qp,
  input  logic [`ROCE_PSN_W-1:0] cur_psn,
  input  logic                   pkt_index_first,
  input  logic                   pl_valid,
  input  roce_pkg::roce_beat_t   pl_beat,
  output logic                   pl_ready,
  input  logic                   credit_return,
  output logic                   tx_valid,
  output roce_pkg::roce_beat_t   tx_beat,
  output roce_pkg::roce_hdr_t    tx_hdr,
  output logic                   pkt_done
);
  import roce_pkg::*;

  localparam int CREDIT_W = $clog2(`ROCE_TX_CREDITS + 1);

  logic [CREDIT_W-1:0]    credits;
  logic [`ROCE_LEN_W-1:0] pkt_bytes;
  logic [`ROCE_LEN_W-1:0] sent_bytes;
  logic [`ROCE_LEN_W-1:0] left_bytes;
  logic [`ROCE_LEN_W-1:0] pmtu_len;
  logic                   accept;
  logic                   beat_first;
  logic                   beat_last;
  logic                   xfer_last;
  logic                   first_pkt;
  logic                   last_pkt;
  roce_hdr_t              hdr_next;

  assign pmtu_len   = {{(`ROCE_LEN_W - $bits(qp.pmtu)){1'b0}}, qp.pmtu};
  assign left_bytes = qp.dma_length - sent_bytes;

  assign beat_first = (pkt_bytes == '0);
  assign xfer_last  = (left_bytes <= `ROCE_KEEP_W);
  assign beat_last  = xfer_last || (pkt_bytes + `ROCE_KEEP_W >= pmtu_len);

  // The word held in the output register spends a credit this cycle.
  assign pl_ready = (credits > CREDIT_W'(tx_valid));
  assign accept   = pl_valid && pl_ready;
  assign pkt_done = tx_valid && tx_beat.last;

  // A packet may start while the previous one's last beat is still on the
  // output, before the config block has advanced its PSN and first flag.
  assign first_pkt = pkt_index_first && !pkt_done;
  assign last_pkt  = (left_bytes <= pmtu_len);

  always_comb begin
    hdr_next              = '0;
    hdr_next.psn          = cur_psn + {{(`ROCE_PSN_W - 1){1'b0}}, pkt_done};
    hdr_next.dest_qp      = qp.rem_qpn;
    hdr_next.ack_req      = last_pkt;
    hdr_next.reth_present = first_pkt;
    if (first_pkt && last_pkt) begin
      hdr_next.op_code = `ROCE_OP_WRITE_ONLY;
    end else if (first_pkt) begin
      hdr_next.op_code = `ROCE_OP_WRITE_FIRST;
    end else if (last_pkt) begin
      hdr_next.op_code = `ROCE_OP_WRITE_LAST;
    end else begin
      hdr_next.op_code = `ROCE_OP_WRITE_MIDDLE;
    end
    if (first_pkt) begin
      hdr_next.v_addr  = qp.rem_addr;
      hdr_next.r_key   = qp.r_key;
      hdr_next.dma_len = qp.dma_length;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits    <= CREDIT_W'(`ROCE_TX_CREDITS);
      tx_valid   <= 1'b0;
      pkt_bytes  <= '0;
      sent_bytes <= '0;
    end else begin
      credits  <= credits - CREDIT_W'(tx_valid) + CREDIT_W'(credit_return);
      tx_valid <= accept;
      if (accept) begin
        if (xfer_last) begin
          sent_bytes <= '0;  // Ready for the next transfer.
          pkt_bytes  <= '0;
        end else begin
          sent_bytes <= sent_bytes + `ROCE_KEEP_W;
          pkt_bytes  <= beat_last ? '0 : pkt_bytes + `ROCE_KEEP_W;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tx_beat.data  <= pl_beat.data;
      tx_beat.keep  <= pl_beat.keep;
      tx_beat.first <= beat_first;
      tx_beat.last  <= beat_last;
      if (beat_first) begin
        tx_hdr <= hdr_next;  // Held until the packet's last beat.
      end
    end
  end

  // The sink must not return more credits than beats it has taken.
  ap_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= CREDIT_W'(`ROCE_TX_CREDITS));

  ap_valid_credit: assert property (@(posedge clk) disable iff (rst)
    tx_valid |-> credits != '0);

endmodule
